/* files.f */
rtl/mem_test_pkg.sv
rtl/mem_test_ctrl.sv
rtl/addr_sequencer.sv
rtl/read_checker.sv
rtl/led_status.sv
rtl/mem_test_top.sv
sim/avl_mem_model.sv
sim/mem_test_assert.sv
sim/tb_mem_test.sv

/* sim/tb_mem_test.sv */
`timescale 1ns/100ps

module tb_mem_test;

    localparam int num_words = 32;

    logic                        clk = 1'b0;
    logic                        global_reset_n;
    logic [1:0]                  cal_mode;
    logic [23:0]                 fault_addr;
    logic                        fault_en;
    logic                        stall_en;
    mem_test_pkg::avl_cmd_t      cmd;
    mem_test_pkg::avl_resp_t     resp;
    mem_test_pkg::mem_status_t   status;
    mem_test_pkg::test_verdict_t verdict;
    logic [2:0]                  leds_n;
    int                          accept_count;

    always #4 clk = ~clk;

    mem_test_top #(.num_words(num_words), .burst_len(4), .led_div(4)) UUT(
        .clk(clk),
        .global_reset_n(global_reset_n),
        .status(status),
        .resp(resp),
        .cmd(cmd),
        .verdict(verdict),
        .leds_n(leds_n));

    avl_mem_model mem0(
        .clk(clk),
        .global_reset_n(global_reset_n),
        .cmd(cmd),
        .resp(resp),
        .status(status),
        .cal_mode(cal_mode),
        .fault_addr(fault_addr),
        .fault_en(fault_en),
        .stall_en(stall_en),
        .accept_count(accept_count));

    //////////////////////////////////////////////////////////////////////
    // checking helpers
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_timeout(input string test, input string what);
        $display("%s: timed out waiting for %s", test, what);
        abort_run();
    endtask

    task automatic check_value(input string test, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %0h, actual %0h", test, expected, actual);
            abort_run();
        end
    endtask

    // address in the low bits, inverted for pattern 1
    function automatic logic [63:0] expected_word(input logic [23:0] addr, input logic sel);
        if (sel) begin
            return {40'hff_ffff_ffff, ~addr};
        end
        else begin
            return {40'h0, addr};
        end
    endfunction

    task automatic check_memory(input string test, input logic sel);
        for (int i = 0; i < num_words; i++) begin
            check_value(test, expected_word(i, sel), mem0.mem[i]);
        end
    endtask

    task automatic wait_finished(input string test, input int limit);
        int cycles;
        cycles = 0;
        while (!verdict.finished) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) report_timeout(test, "finished");
        end
    endtask

    task automatic wait_led_change(input string test, input logic [2:0] prev,
                                   output logic [2:0] now);
        int cycles;
        cycles = 0;
        now = leds_n;
        while (now == prev) begin
            @(negedge clk);
            cycles++;
            if (cycles > 40) report_timeout(test, "a change of leds_n");
            now = leds_n;
        end
    endtask

    // reset, set the model up, release calibration and run to the verdict
    task automatic run_until_finished(input string test, input logic [1:0] mode,
                                      input logic stall, input logic fault, input int limit);
        int cycles;
        @(negedge clk);
        global_reset_n = 1'b0;
        cal_mode       = 2'd0;
        stall_en       = stall;
        fault_en       = fault;
        repeat (8) @(negedge clk);
        global_reset_n = 1'b1;
        check_value(test, 64'h0, {61'h0, verdict});
        check_value(test, 64'h0, {61'h0, cmd.read_req, cmd.write_req, cmd.burstbegin});
        check_value(test, 64'h7, {61'h0, leds_n});
        @(negedge clk);
        cal_mode = mode;
        if (mode == 2'd1) begin
            cycles = 0;
            while (!cmd.write_req) begin
                @(negedge clk);
                cycles++;
                if (cycles > 4) report_timeout(test, "the first write command");
            end
        end
        wait_finished(test, limit);
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic clean_pass();
        run_until_finished("clean_pass", 2'd1, 1'b0, 1'b0, 4000);
        check_value("clean_pass", 64'h6, {61'h0, verdict});
        check_memory("clean_pass", 1'b1);
    endtask

    task automatic backpressure_pass();
        run_until_finished("backpressure_pass", 2'd1, 1'b1, 1'b0, 8000);
        check_value("backpressure_pass", 64'h6, {61'h0, verdict});
        check_memory("backpressure_pass", 1'b1);
    endtask

    task automatic data_fault();
        run_until_finished("data_fault", 2'd1, 1'b1, 1'b1, 8000);
        check_value("data_fault", 64'h5, {61'h0, verdict});
    endtask

    task automatic cal_failure();
        run_until_finished("cal_failure", 2'd2, 1'b0, 1'b0, 2);
        repeat (20) @(negedge clk);                 // give a stray command time to show
        check_value("cal_failure", 64'h5, {61'h0, verdict});
        check_value("cal_failure", 64'h0, 64'(accept_count));
    endtask

    task automatic led_count_on_pass();
        logic [2:0] prev;
        logic [2:0] now;
        logic [2:0] expected;
        run_until_finished("led_count_on_pass", 2'd1, 1'b0, 1'b0, 4000);
        prev = leds_n;
        repeat (10) begin
            wait_led_change("led_count_on_pass", prev, now);
            expected = ~(~prev + 3'd1);
            check_value("led_count_on_pass", {61'h0, expected}, {61'h0, now});
            prev = now;
        end
    endtask

    task automatic led_blink_on_fail();
        logic [2:0] prev;
        logic [2:0] now;
        logic [2:0] expected;
        run_until_finished("led_blink_on_fail", 2'd1, 1'b0, 1'b1, 4000);
        prev = leds_n;
        check_value("led_blink_on_fail", 64'h7, {61'h0, prev});
        repeat (6) begin
            wait_led_change("led_blink_on_fail", prev, now);
            expected = ~prev;                       // all off and all on in turn
            check_value("led_blink_on_fail", {61'h0, expected}, {61'h0, now});
            prev = now;
        end
    endtask

    initial begin
        global_reset_n = 1'b0;
        cal_mode       = 2'd0;
        fault_addr     = 24'd13;
        fault_en       = 1'b0;
        stall_en       = 1'b0;
        clean_pass();
        backpressure_pass();
        data_fault();
        cal_failure();
        led_count_on_pass();
        led_blink_on_fail();
        if (UUT.assert0.error_count == 0) begin
            $display("all tests passed");
            $finish;
        end
        else begin
            $display("%0d bus or verdict assertions failed", UUT.assert0.error_count);
            abort_run();
        end
    end

endmodule

/* sim/mem_test_assert.sv */
`timescale 1ns/100ps

module mem_test_assert(
    input logic                        clk,
    input logic                        global_reset_n,
    input mem_test_pkg::avl_cmd_t      cmd,
    input mem_test_pkg::avl_resp_t     resp,
    input mem_test_pkg::test_verdict_t verdict);

    logic req;
    int   error_count = 0;

    assign req = cmd.read_req || cmd.write_req;

    cmd_held: assert property (@(posedge clk) disable iff (!global_reset_n)
        (req && !resp.ready) |=> $stable(cmd))
        else begin
            error_count++;
            $error("command changed while ready was low");
        end

    one_req: assert property (@(posedge clk) disable iff (!global_reset_n)
        !(cmd.read_req && cmd.write_req))
        else begin
            error_count++;
            $error("read and write requested together");
        end

    begin_with_req: assert property (@(posedge clk) disable iff (!global_reset_n)
        cmd.burstbegin |-> req)
        else begin
            error_count++;
            $error("burstbegin without a request");
        end

    one_verdict: assert property (@(posedge clk) disable iff (!global_reset_n)
        !(verdict.pass && verdict.fail))
        else begin
            error_count++;
            $error("pass and fail both high");
        end

endmodule

bind mem_test_top mem_test_assert assert0(
    .clk(clk),
    .global_reset_n(global_reset_n),
    .cmd(cmd),
    .resp(resp),
    .verdict(verdict));

/* sim/avl_mem_model.sv */
`timescale 1ns/100ps

module avl_mem_model #(
    parameter int depth = 64
) (
    input  logic                            clk,
    input  logic                            global_reset_n,

    input  mem_test_pkg::avl_cmd_t          cmd,
    output mem_test_pkg::avl_resp_t         resp,
    output mem_test_pkg::mem_status_t       status,

    input  logic [1:0]                      cal_mode,      // 0 busy, 1 success, 2 fail
    input  logic [mem_test_pkg::addr_w-1:0] fault_addr,
    input  logic                            fault_en,
    input  logic                            stall_en,
    output int                              accept_count);

    logic [mem_test_pkg::data_w-1:0] mem [0:depth-1];

    logic [mem_test_pkg::addr_w-1:0] pend_addr [$];    // read words in flight, in order
    int                              pend_due [$];
    logic [mem_test_pkg::addr_w-1:0] ret_addr;
    logic [mem_test_pkg::data_w-1:0] ret_word;
    logic [mem_test_pkg::data_w-1:0] wr_word;
    integer                          seed = 22;
    int                              cycle;
    int                              due;
    int                              wr_beat;
    int                              beat;
    int                              lane;
    int                              i;

    assign status.init_done   = (cal_mode != 2'd0);
    assign status.cal_success = (cal_mode == 2'd1);
    assign status.cal_fail    = (cal_mode == 2'd2);

    always @(posedge clk or negedge global_reset_n) begin
        if (!global_reset_n) begin
            resp         <= '0;
            accept_count <= 0;
            cycle        = 0;
            wr_beat      = 0;
            pend_addr.delete();
            pend_due.delete();
            for (i = 0; i < depth; i++) begin
                mem[i] = 64'h5a5a_5a5a_0000_0000 | (64'(i) * 64'h0001_0001);
            end
        end
        else begin
            cycle = cycle + 1;

            //////////////////////////////////////////////////////////////////////
            // command side
            //////////////////////////////////////////////////////////////////////
            if (resp.ready && (cmd.read_req || cmd.write_req)) begin
                accept_count <= accept_count + 1;
                if (cmd.write_req) begin
                    beat = cmd.burstbegin ? 0 : wr_beat;
                    if (beat < cmd.size) begin              // beats past the burst are dropped
                        wr_word = mem[(cmd.addr + beat) % depth];
                        for (lane = 0; lane < mem_test_pkg::be_w; lane++) begin
                            if (cmd.be[lane]) begin
                                wr_word[lane*8 +: 8] = cmd.wdata[lane*8 +: 8];
                            end
                        end
                        mem[(cmd.addr + beat) % depth] = wr_word;
                    end
                    wr_beat = beat + 1;
                end
                else begin
                    due = cycle + 2 + ($unsigned($random(seed)) % 5);    // 2 to 6 cycles
                    for (i = 0; i < cmd.size; i++) begin
                        pend_addr.push_back(cmd.addr + i);
                        pend_due.push_back(due);
                    end
                end
            end

            // one word back per cycle once the head is due
            if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin
                ret_addr = pend_addr.pop_front();
                due      = pend_due.pop_front();
                ret_word = mem[ret_addr % depth];
                if (fault_en && ret_addr == fault_addr) begin
                    ret_word = ret_word ^ 64'h1;
                end
                resp.rdata_valid <= 1'b1;
                resp.rdata       <= ret_word;
            end
            else begin
                resp.rdata_valid <= 1'b0;
            end

            resp.ready <= stall_en ? (($random(seed) & 3) != 0) : 1'b1;
        end
    end

endmodule

/* rtl/mem_test_top.sv */
`timescale 1ns/100ps

module mem_test_top #(
    parameter int num_words = 256,
    parameter int burst_len = 4,
    parameter int led_div   = 25000000
) (
    input  logic                        clk,
    input  logic                        global_reset_n,

    input  mem_test_pkg::mem_status_t   status,
    input  mem_test_pkg::avl_resp_t     resp,
    output mem_test_pkg::avl_cmd_t      cmd,

    output mem_test_pkg::test_verdict_t verdict,
    output logic [2:0]                  leds_n);

    logic start;
    logic write_phase;
    logic pattern_sel;
    logic seq_done;
    logic chk_done;
    logic mismatch;

    mem_test_ctrl ctrl0(
        .clk(clk),
        .global_reset_n(global_reset_n),
        .status(status),
        .seq_done(seq_done),
        .chk_done(chk_done),
        .mismatch(mismatch),
        .start(start),
        .write_phase(write_phase),
        .pattern_sel(pattern_sel),
        .verdict(verdict));

    addr_sequencer #(.num_words(num_words), .burst_len(burst_len)) seq0(
        .clk(clk),
        .global_reset_n(global_reset_n),
        .start(start),
        .write_phase(write_phase),
        .pattern_sel(pattern_sel),
        .ready(resp.ready),
        .cmd(cmd),
        .done(seq_done));

    read_checker #(.num_words(num_words)) chk0(
        .clk(clk),
        .global_reset_n(global_reset_n),
        .start(start),
        .pattern_sel(pattern_sel),
        .rdata_valid(resp.rdata_valid),
        .rdata(resp.rdata),
        .done(chk_done),
        .mismatch(mismatch));

    led_status #(.led_div(led_div)) led0(
        .clk(clk),
        .global_reset_n(global_reset_n),
        .verdict(verdict),
        .leds_n(leds_n));

endmodule

/* rtl/led_status.sv */
`timescale 1ns/100ps

module led_status #(
    parameter int led_div = 25000000
) (
    input  logic                        clk,
    input  logic                        global_reset_n,

    input  mem_test_pkg::test_verdict_t verdict,

    output logic [2:0]                  leds_n);

    localparam int div_w = $clog2(led_div) + 1;

    localparam logic [div_w-1:0] div_last = div_w'(led_div - 1);

    logic [div_w-1:0] div_q;
    logic             tick;
    logic [2:0]       leds;

    assign leds_n = ~leds;

    // slow tick, one cycle every led_div cycles
    always_ff @(posedge clk or negedge global_reset_n) begin
        if (!global_reset_n) begin
            div_q <= '0;
            tick  <= 1'b0;
        end
        else begin
            tick  <= (div_q == div_last);
            div_q <= (div_q == div_last) ? '0 : div_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge global_reset_n) begin
        if (!global_reset_n) begin
            leds <= 3'h0;
        end
        else if (verdict.finished && tick) begin
            leds <= verdict.pass ? leds + 3'h1 : ~leds;    // count on pass, blink on fail
        end
    end

endmodule

/* rtl/read_checker.sv */
`timescale 1ns/100ps

module read_checker #(
    parameter int num_words = 256
) (
    input  logic                            clk,
    input  logic                            global_reset_n,

    input  logic                            start,
    input  logic                            pattern_sel,
    input  logic                            rdata_valid,
    input  logic [mem_test_pkg::data_w-1:0] rdata,

    output logic                            done,
    output logic                            mismatch);

    localparam int addr_w = mem_test_pkg::addr_w;

    localparam logic [addr_w-1:0] last_word = addr_w'(num_words - 1);

    logic [addr_w-1:0]               count_q;     // address of the next expected word
    logic [mem_test_pkg::data_w-1:0] expected;
    logic                            word_bad;

    assign expected = mem_test_pkg::pattern_word(count_q, pattern_sel);
    assign word_bad = rdata_valid && (rdata != expected);

    //////////////////////////////////////////////////////////////////////
    // return counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge global_reset_n) begin
        if (!global_reset_n) begin
            count_q <= '0;
            done    <= 1'b0;
        end
        else begin
            done <= 1'b0;

            if (start) begin
                count_q <= '0;
            end
            else if (rdata_valid) begin
                count_q <= count_q + 1'b1;
                done    <= (count_q == last_word);   // all words back
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sticky mismatch
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge global_reset_n) begin
        if (!global_reset_n) begin
            mismatch <= 1'b0;
        end
        else if (word_bad) begin
            mismatch <= 1'b1;
        end
    end

endmodule

/* rtl/addr_sequencer.sv */
`timescale 1ns/100ps

module addr_sequencer #(
    parameter int num_words = 256,
    parameter int burst_len = 4
) (
    input  logic                     clk,
    input  logic                     global_reset_n,

    input  logic                     start,
    input  logic                     write_phase,
    input  logic                     pattern_sel,
    input  logic                     ready,

    output mem_test_pkg::avl_cmd_t   cmd,
    output logic                     done);

    localparam int addr_w = mem_test_pkg::addr_w;
    localparam int size_w = mem_test_pkg::size_w;

    localparam logic [addr_w-1:0] last_base = addr_w'(num_words - burst_len);
    localparam logic [size_w-1:0] beat_last = size_w'(burst_len - 1);

    logic                            read_req;
    logic                            write_req;
    logic                            burstbegin;
    logic [addr_w-1:0]               base_q;
    logic [size_w-1:0]               beat_q;
    logic [mem_test_pkg::data_w-1:0] wdata_q;

    logic              accept;
    logic [addr_w-1:0] word_next;

    assign accept    = ready && (read_req || write_req);
    assign word_next = base_q + addr_w'(beat_q) + addr_w'(1);   // next write word

    assign cmd.read_req   = read_req;
    assign cmd.write_req  = write_req;
    assign cmd.burstbegin = burstbegin;
    assign cmd.addr       = base_q;
    assign cmd.size       = size_w'(burst_len);
    assign cmd.wdata      = wdata_q;
    assign cmd.be         = '1;

    always_ff @(posedge clk or negedge global_reset_n) begin
        if (!global_reset_n) begin
            read_req   <= 1'b0;
            write_req  <= 1'b0;
            burstbegin <= 1'b0;
            base_q     <= '0;
            beat_q     <= '0;
            done       <= 1'b0;
        end
        else begin
            done <= 1'b0;

            if (start) begin
                read_req   <= !write_phase;
                write_req  <= write_phase;
                burstbegin <= 1'b1;
                base_q     <= '0;
                beat_q     <= '0;
            end
            else if (accept) begin
                if (write_req && beat_q != beat_last) begin
                    beat_q     <= beat_q + 1'b1;
                    burstbegin <= 1'b0;
                end
                else if (base_q == last_base) begin
                    read_req   <= 1'b0;                 // sweep complete
                    write_req  <= 1'b0;
                    burstbegin <= 1'b0;
                    beat_q     <= '0;
                    done       <= 1'b1;
                end
                else begin
                    base_q     <= base_q + addr_w'(burst_len);
                    beat_q     <= '0;
                    burstbegin <= 1'b1;
                end
            end
        end
    end

    // payload moves only with start or an accepted beat
    always_ff @(posedge clk) begin
        if (start) begin
            wdata_q <= mem_test_pkg::pattern_word('0, pattern_sel);
        end
        else if (accept) begin
            wdata_q <= mem_test_pkg::pattern_word(word_next, pattern_sel);
        end
    end

endmodule

/* rtl/mem_test_ctrl.sv */
`timescale 1ns/100ps

module mem_test_ctrl(
    input  logic                        clk,
    input  logic                        global_reset_n,

    input  mem_test_pkg::mem_status_t   status,
    input  logic                        seq_done,
    input  logic                        chk_done,
    input  logic                        mismatch,

    output logic                        start,
    output logic                        write_phase,
    output logic                        pattern_sel,
    output mem_test_pkg::test_verdict_t verdict);

    typedef enum logic [2:0] {
        st_wait_cal,
        st_write,
        st_read,
        st_next,
        st_finished
    } state_t;

    state_t state;
    state_t state_next;

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;

        case (state)
            st_wait_cal: begin
                if (status.cal_fail) begin
                    state_next = st_finished;
                end
                else if (status.init_done && status.cal_success) begin
                    state_next = st_write;
                end
            end

            st_write: begin
                if (seq_done) begin
                    state_next = st_read;
                end
            end

            st_read: begin
                // stop early on a mismatch, otherwise go on to pattern 1
                if (chk_done) begin
                    if (mismatch || pattern_sel) begin
                        state_next = st_finished;
                    end
                    else begin
                        state_next = st_next;
                    end
                end
            end

            st_next: state_next = st_write;

            st_finished: state_next = st_finished;    // hold until reset

            default: state_next = st_wait_cal;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // state and outputs
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge global_reset_n) begin
        if (!global_reset_n) begin
            state       <= st_wait_cal;
            start       <= 1'b0;
            write_phase <= 1'b0;
            pattern_sel <= 1'b0;
            verdict     <= '0;
        end
        else begin
            state <= state_next;
            start <= 1'b0;                              // one cycle only

            case (state)
                st_wait_cal: begin
                    if (status.cal_fail) begin
                        verdict.finished <= 1'b1;
                        verdict.fail     <= 1'b1;
                    end
                    else if (status.init_done && status.cal_success) begin
                        start       <= 1'b1;
                        write_phase <= 1'b1;
                        pattern_sel <= 1'b0;
                    end
                end

                st_write: begin
                    if (seq_done) begin
                        start       <= 1'b1;
                        write_phase <= 1'b0;            // read back what was written
                    end
                end

                st_read: begin
                    if (chk_done) begin
                        if (mismatch) begin
                            verdict.finished <= 1'b1;
                            verdict.fail     <= 1'b1;
                        end
                        else if (pattern_sel) begin
                            verdict.finished <= 1'b1;
                            verdict.pass     <= 1'b1;
                        end
                        else begin
                            pattern_sel <= 1'b1;
                        end
                    end
                end

                st_next: begin
                    start       <= 1'b1;
                    write_phase <= 1'b1;
                end

                default: ;
            endcase
        end
    end

endmodule

/* rtl/mem_test_pkg.sv */
package mem_test_pkg;

    //////////////////////////////////////////////////////////////////////
    // bus widths
    //////////////////////////////////////////////////////////////////////

    localparam int addr_w = 24;    // burst-word address
    localparam int data_w = 64;
    localparam int be_w   = 8;
    localparam int size_w = 7;

    // command toward the memory controller
    typedef struct packed {
        logic              read_req;
        logic              write_req;
        logic              burstbegin;
        logic [addr_w-1:0] addr;
        logic [size_w-1:0] size;
        logic [data_w-1:0] wdata;
        logic [be_w-1:0]   be;
    } avl_cmd_t;

    typedef struct packed {
        logic              ready;
        logic              rdata_valid;
        logic [data_w-1:0] rdata;
    } avl_resp_t;

    typedef struct packed {
        logic init_done;
        logic cal_success;
        logic cal_fail;
    } mem_status_t;

    typedef struct packed {
        logic finished;
        logic pass;
        logic fail;
    } test_verdict_t;

    // expected data for a word, pattern 1 is the inverse of pattern 0
    function automatic logic [data_w-1:0] pattern_word(input logic [addr_w-1:0] addr,
                                                       input logic sel);
        logic [data_w-1:0] word;
        word = {{(data_w - addr_w){1'b0}}, addr};
        return sel ? ~word : word;
    endfunction

endpackage
